// ==== rvga_isa_pkg.sv ====
`default_nettype none

package rvga_isa_pkg;

    localparam int XLEN       = 32; // Data and PC width.
    localparam int ILEN       = 32; // Instruction word width.
    localparam int REG_ADDR_W = 5;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // Selects sub and sra.

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B // Used by LUI.
    } alu_op_e;

endpackage

`default_nettype wire

// ==== rvga_pipe_pkg.sv ====
`default_nettype none

package rvga_pipe_pkg;

    localparam int NUM_REGS     = 32;
    localparam int PC_STEP      = 4;
    localparam int PIPE_LATENCY = 3; // Edges from acceptance to writeback.

    typedef enum logic {
        OPB_REG,
        OPB_IMM
    } op_b_sel_e;

endpackage

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic [rvga_isa_pkg::REG_ADDR_W-1:0]   rs1_i,
    input  logic [rvga_isa_pkg::REG_ADDR_W-1:0]   rs2_i,
    input  logic [rvga_isa_pkg::REG_ADDR_W-1:0]   rd_i,
    input  logic                                  rd_we_i,
    input  logic [rvga_isa_pkg::XLEN-1:0]         rd_data_i,
    output logic [rvga_isa_pkg::XLEN-1:0]         rs1_data_o,
    output logic [rvga_isa_pkg::XLEN-1:0]         rs2_data_o
);

    logic [rvga_isa_pkg::XLEN-1:0] regs [rvga_pipe_pkg::NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < rvga_pipe_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we_i) begin
            regs[rd_i] <= rd_data_i; // Decode never enables x0.
        end
    end

    // x0 first, then write-through, then the array.
    assign rs1_data_o = (rs1_i == '0) ? '0 :
                        (rd_we_i && rs1_i == rd_i) ? rd_data_i : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 :
                        (rd_we_i && rs2_i == rd_i) ? rd_data_i : regs[rs2_i];

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  valid_i,
    input  logic [rvga_isa_pkg::XLEN-1:0]         pc_i,
    input  logic [rvga_isa_pkg::ILEN-1:0]         instr_i,
    output logic                                  valid_o,
    output logic [rvga_isa_pkg::XLEN-1:0]         pc_o,
    output logic [rvga_isa_pkg::REG_ADDR_W-1:0]   rs1_o,
    output logic [rvga_isa_pkg::REG_ADDR_W-1:0]   rs2_o,
    output logic [rvga_isa_pkg::REG_ADDR_W-1:0]   rd_o,
    output logic [rvga_isa_pkg::XLEN-1:0]         imm_o,
    output rvga_isa_pkg::alu_op_e                 alu_op_o,
    output rvga_pipe_pkg::op_b_sel_e              op_b_sel_o,
    output logic                                  rd_we_o
);

    rvga_isa_pkg::opcode_e               opcode;
    logic [2:0]                          funct3;
    logic [6:0]                          funct7;
    logic [rvga_isa_pkg::REG_ADDR_W-1:0] rd;
    logic [rvga_isa_pkg::XLEN-1:0]       imm;
    rvga_isa_pkg::alu_op_e               alu_op;
    rvga_pipe_pkg::op_b_sel_e            op_b_sel;
    logic                                legal;

    assign opcode = rvga_isa_pkg::opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rd     = instr_i[11:7];

    always_comb begin
        alu_op   = rvga_isa_pkg::ALU_ADD;
        op_b_sel = rvga_pipe_pkg::OPB_IMM;
        imm      = {{20{instr_i[31]}}, instr_i[31:20]}; // I-type.
        legal    = 1'b1;
        case (opcode)
            rvga_isa_pkg::OPC_OP: begin
                op_b_sel = rvga_pipe_pkg::OPB_REG;
                if (funct7 == rvga_isa_pkg::FUNCT7_BASE) begin
                    case (funct3)
                        3'b000: alu_op = rvga_isa_pkg::ALU_ADD;
                        3'b001: alu_op = rvga_isa_pkg::ALU_SLL;
                        3'b010: alu_op = rvga_isa_pkg::ALU_SLT;
                        3'b011: alu_op = rvga_isa_pkg::ALU_SLTU;
                        3'b100: alu_op = rvga_isa_pkg::ALU_XOR;
                        3'b101: alu_op = rvga_isa_pkg::ALU_SRL;
                        3'b110: alu_op = rvga_isa_pkg::ALU_OR;
                        default: alu_op = rvga_isa_pkg::ALU_AND;
                    endcase
                end else if (funct7 == rvga_isa_pkg::FUNCT7_ALT && funct3 == 3'b000) begin
                    alu_op = rvga_isa_pkg::ALU_SUB;
                end else if (funct7 == rvga_isa_pkg::FUNCT7_ALT && funct3 == 3'b101) begin
                    alu_op = rvga_isa_pkg::ALU_SRA;
                end else begin
                    legal = 1'b0;
                end
            end
            rvga_isa_pkg::OPC_OP_IMM: begin
                case (funct3)
                    3'b000: alu_op = rvga_isa_pkg::ALU_ADD;
                    3'b010: alu_op = rvga_isa_pkg::ALU_SLT;
                    3'b011: alu_op = rvga_isa_pkg::ALU_SLTU;
                    3'b100: alu_op = rvga_isa_pkg::ALU_XOR;
                    3'b110: alu_op = rvga_isa_pkg::ALU_OR;
                    3'b111: alu_op = rvga_isa_pkg::ALU_AND;
                    3'b001: begin
                        alu_op = rvga_isa_pkg::ALU_SLL;
                        legal  = (funct7 == rvga_isa_pkg::FUNCT7_BASE);
                    end
                    default: begin
                        alu_op = (funct7 == rvga_isa_pkg::FUNCT7_ALT) ?
                                 rvga_isa_pkg::ALU_SRA : rvga_isa_pkg::ALU_SRL;
                        legal  = (funct7 == rvga_isa_pkg::FUNCT7_BASE) ||
                                 (funct7 == rvga_isa_pkg::FUNCT7_ALT);
                    end
                endcase
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm = {27'b0, instr_i[24:20]}; // Shamt only.
                end
            end
            rvga_isa_pkg::OPC_LUI: begin
                alu_op = rvga_isa_pkg::ALU_PASS_B;
                imm    = {instr_i[31:12], 12'b0};
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            rd_we_o <= 1'b0;
        end else begin
            valid_o <= valid_i && legal;
            rd_we_o <= valid_i && legal && (rd != '0); // No writes to x0.
        end
    end

    always_ff @(posedge clk_i) begin
        pc_o       <= pc_i;
        rs1_o      <= instr_i[19:15];
        rs2_o      <= instr_i[24:20];
        rd_o       <= rd;
        imm_o      <= imm;
        alu_op_o   <= alu_op;
        op_b_sel_o <= op_b_sel;
    end

endmodule

`default_nettype wire

// ==== rfetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rfetch_stage (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  valid_i,
    input  logic [rvga_isa_pkg::XLEN-1:0]         pc_i,
    input  logic [rvga_isa_pkg::REG_ADDR_W-1:0]   rs1_i,
    input  logic [rvga_isa_pkg::REG_ADDR_W-1:0]   rs2_i,
    input  logic [rvga_isa_pkg::REG_ADDR_W-1:0]   rd_i,
    input  logic [rvga_isa_pkg::XLEN-1:0]         imm_i,
    input  rvga_isa_pkg::alu_op_e                 alu_op_i,
    input  rvga_pipe_pkg::op_b_sel_e              op_b_sel_i,
    input  logic                                  rd_we_i,
    input  logic [rvga_isa_pkg::XLEN-1:0]         rf_rs1_data_i,
    input  logic [rvga_isa_pkg::XLEN-1:0]         rf_rs2_data_i,
    input  logic                                  ex_fwd_we_i,
    input  logic [rvga_isa_pkg::REG_ADDR_W-1:0]   ex_fwd_rd_i,
    input  logic [rvga_isa_pkg::XLEN-1:0]         ex_fwd_data_i,
    input  logic                                  wb_we_i,
    input  logic [rvga_isa_pkg::REG_ADDR_W-1:0]   wb_rd_i,
    input  logic [rvga_isa_pkg::XLEN-1:0]         wb_data_i,
    output logic                                  valid_o,
    output logic [rvga_isa_pkg::XLEN-1:0]         pc_o,
    output logic [rvga_isa_pkg::REG_ADDR_W-1:0]   rd_o,
    output logic [rvga_isa_pkg::XLEN-1:0]         rs1_data_o,
    output logic [rvga_isa_pkg::XLEN-1:0]         rs2_data_o,
    output logic [rvga_isa_pkg::XLEN-1:0]         imm_o,
    output rvga_isa_pkg::alu_op_e                 alu_op_o,
    output rvga_pipe_pkg::op_b_sel_e              op_b_sel_o,
    output logic                                  rd_we_o
);

    logic [rvga_isa_pkg::XLEN-1:0] rs1_data;
    logic [rvga_isa_pkg::XLEN-1:0] rs2_data;

    // Youngest producer wins: execute, then writeback, then regfile.
    function automatic logic [rvga_isa_pkg::XLEN-1:0] fwd_operand(
        input logic [rvga_isa_pkg::REG_ADDR_W-1:0] rs,
        input logic [rvga_isa_pkg::XLEN-1:0]       rf_data
    );
        if (ex_fwd_we_i && ex_fwd_rd_i == rs) begin
            return ex_fwd_data_i;
        end else if (wb_we_i && wb_rd_i == rs) begin
            return wb_data_i;
        end
        return rf_data;
    endfunction

    always_comb begin
        rs1_data = fwd_operand(rs1_i, rf_rs1_data_i);
        rs2_data = fwd_operand(rs2_i, rf_rs2_data_i);
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            rd_we_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            rd_we_o <= rd_we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        pc_o       <= pc_i;
        rd_o       <= rd_i;
        rs1_data_o <= rs1_data;
        rs2_data_o <= rs2_data;
        imm_o      <= imm_i;
        alu_op_o   <= alu_op_i;
        op_b_sel_o <= op_b_sel_i;
    end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  valid_i,
    input  logic [rvga_isa_pkg::XLEN-1:0]         pc_i,
    input  logic [rvga_isa_pkg::REG_ADDR_W-1:0]   rd_i,
    input  logic [rvga_isa_pkg::XLEN-1:0]         rs1_data_i,
    input  logic [rvga_isa_pkg::XLEN-1:0]         rs2_data_i,
    input  logic [rvga_isa_pkg::XLEN-1:0]         imm_i,
    input  rvga_isa_pkg::alu_op_e                 alu_op_i,
    input  rvga_pipe_pkg::op_b_sel_e              op_b_sel_i,
    input  logic                                  rd_we_i,
    output logic                                  fwd_we_o,
    output logic [rvga_isa_pkg::REG_ADDR_W-1:0]   fwd_rd_o,
    output logic [rvga_isa_pkg::XLEN-1:0]         fwd_data_o,
    output logic                                  wb_valid_o,
    output logic [rvga_isa_pkg::XLEN-1:0]         wb_pc_o,
    output logic [rvga_isa_pkg::REG_ADDR_W-1:0]   wb_rd_o,
    output logic [rvga_isa_pkg::XLEN-1:0]         wb_data_o,
    output logic                                  wb_we_o
);

    logic [rvga_isa_pkg::XLEN-1:0] op_a;
    logic [rvga_isa_pkg::XLEN-1:0] op_b;
    logic [4:0]                    shamt;
    logic [rvga_isa_pkg::XLEN-1:0] result;

    assign op_a  = rs1_data_i;
    assign op_b  = (op_b_sel_i == rvga_pipe_pkg::OPB_IMM) ? imm_i : rs2_data_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            rvga_isa_pkg::ALU_ADD:    result = op_a + op_b;
            rvga_isa_pkg::ALU_SUB:    result = op_a - op_b;
            rvga_isa_pkg::ALU_SLL:    result = op_a << shamt;
            rvga_isa_pkg::ALU_SLT:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            rvga_isa_pkg::ALU_SLTU:   result = {31'b0, op_a < op_b};
            rvga_isa_pkg::ALU_XOR:    result = op_a ^ op_b;
            rvga_isa_pkg::ALU_SRL:    result = op_a >> shamt;
            rvga_isa_pkg::ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
            rvga_isa_pkg::ALU_OR:     result = op_a | op_b;
            rvga_isa_pkg::ALU_AND:    result = op_a & op_b;
            rvga_isa_pkg::ALU_PASS_B: result = op_b;
            default:                  result = '0;
        endcase
    end

    assign fwd_we_o   = valid_i && rd_we_i; // Bypass into register fetch.
    assign fwd_rd_o   = rd_i;
    assign fwd_data_o = result;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else begin
            wb_valid_o <= valid_i;
            wb_we_o    <= valid_i && rd_we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_pc_o   <= pc_i;
        wb_rd_o   <= rd_i;
        wb_data_o <= result;
    end

endmodule

`default_nettype wire

// ==== rvga_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvga_core (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  instr_valid_i,
    input  logic [rvga_isa_pkg::ILEN-1:0]         instr_i,
    output logic                                  wb_valid_o,
    output logic [rvga_isa_pkg::XLEN-1:0]         wb_pc_o,
    output logic [rvga_isa_pkg::REG_ADDR_W-1:0]   wb_rd_o,
    output logic [rvga_isa_pkg::XLEN-1:0]         wb_data_o
);

    logic [rvga_isa_pkg::XLEN-1:0]       pc;
    logic                                dec_valid;
    logic [rvga_isa_pkg::XLEN-1:0]       dec_pc;
    logic [rvga_isa_pkg::REG_ADDR_W-1:0] dec_rs1;
    logic [rvga_isa_pkg::REG_ADDR_W-1:0] dec_rs2;
    logic [rvga_isa_pkg::REG_ADDR_W-1:0] dec_rd;
    logic [rvga_isa_pkg::XLEN-1:0]       dec_imm;
    rvga_isa_pkg::alu_op_e               dec_alu_op;
    rvga_pipe_pkg::op_b_sel_e            dec_op_b_sel;
    logic                                dec_rd_we;
    logic [rvga_isa_pkg::XLEN-1:0]       regf_rs1_data;
    logic [rvga_isa_pkg::XLEN-1:0]       regf_rs2_data;
    logic                                rf_valid;
    logic [rvga_isa_pkg::XLEN-1:0]       rf_pc;
    logic [rvga_isa_pkg::REG_ADDR_W-1:0] rf_rd;
    logic [rvga_isa_pkg::XLEN-1:0]       rf_rs1_data;
    logic [rvga_isa_pkg::XLEN-1:0]       rf_rs2_data;
    logic [rvga_isa_pkg::XLEN-1:0]       rf_imm;
    rvga_isa_pkg::alu_op_e               rf_alu_op;
    rvga_pipe_pkg::op_b_sel_e            rf_op_b_sel;
    logic                                rf_rd_we;
    logic                                ex_fwd_we;
    logic [rvga_isa_pkg::REG_ADDR_W-1:0] ex_fwd_rd;
    logic [rvga_isa_pkg::XLEN-1:0]       ex_fwd_data;
    logic                                wb_we;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc <= '0;
        end else if (instr_valid_i) begin
            pc <= pc + rvga_isa_pkg::XLEN'(rvga_pipe_pkg::PC_STEP); // Illegal ones step too.
        end
    end

    decode_stage decode_stage_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .valid_i    (instr_valid_i),
        .pc_i       (pc),
        .instr_i    (instr_i),
        .valid_o    (dec_valid),
        .pc_o       (dec_pc),
        .rs1_o      (dec_rs1),
        .rs2_o      (dec_rs2),
        .rd_o       (dec_rd),
        .imm_o      (dec_imm),
        .alu_op_o   (dec_alu_op),
        .op_b_sel_o (dec_op_b_sel),
        .rd_we_o    (dec_rd_we)
    );

    regfile regfile_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_i      (dec_rs1),
        .rs2_i      (dec_rs2),
        .rd_i       (wb_rd_o),
        .rd_we_i    (wb_we),
        .rd_data_i  (wb_data_o),
        .rs1_data_o (regf_rs1_data),
        .rs2_data_o (regf_rs2_data)
    );

    rfetch_stage rfetch_stage_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .valid_i       (dec_valid),
        .pc_i          (dec_pc),
        .rs1_i         (dec_rs1),
        .rs2_i         (dec_rs2),
        .rd_i          (dec_rd),
        .imm_i         (dec_imm),
        .alu_op_i      (dec_alu_op),
        .op_b_sel_i    (dec_op_b_sel),
        .rd_we_i       (dec_rd_we),
        .rf_rs1_data_i (regf_rs1_data),
        .rf_rs2_data_i (regf_rs2_data),
        .ex_fwd_we_i   (ex_fwd_we),
        .ex_fwd_rd_i   (ex_fwd_rd),
        .ex_fwd_data_i (ex_fwd_data),
        .wb_we_i       (wb_we),
        .wb_rd_i       (wb_rd_o),
        .wb_data_i     (wb_data_o),
        .valid_o       (rf_valid),
        .pc_o          (rf_pc),
        .rd_o          (rf_rd),
        .rs1_data_o    (rf_rs1_data),
        .rs2_data_o    (rf_rs2_data),
        .imm_o         (rf_imm),
        .alu_op_o      (rf_alu_op),
        .op_b_sel_o    (rf_op_b_sel),
        .rd_we_o       (rf_rd_we)
    );

    execute_stage execute_stage_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .valid_i    (rf_valid),
        .pc_i       (rf_pc),
        .rd_i       (rf_rd),
        .rs1_data_i (rf_rs1_data),
        .rs2_data_i (rf_rs2_data),
        .imm_i      (rf_imm),
        .alu_op_i   (rf_alu_op),
        .op_b_sel_i (rf_op_b_sel),
        .rd_we_i    (rf_rd_we),
        .fwd_we_o   (ex_fwd_we),
        .fwd_rd_o   (ex_fwd_rd),
        .fwd_data_o (ex_fwd_data),
        .wb_valid_o (wb_valid_o),
        .wb_pc_o    (wb_pc_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o),
        .wb_we_o    (wb_we)
    );

endmodule

`default_nettype wire

// ==== tb_rvga_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rvga_core;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int N_IDLE_START = 4;
    localparam int N_ZERO_ADDS  = 4;
    localparam int N_RAND_IMM   = 64;
    localparam int N_RAND_REG   = 64;
    localparam int N_CHAIN      = 26;
    localparam int N_MIX        = 40;
    localparam int N_X0         = 10;
    localparam int N_DRAIN      = rvga_pipe_pkg::PIPE_LATENCY + 1;
    localparam int TOTAL_SLOTS  = 1 + N_IDLE_START + N_ZERO_ADDS + N_RAND_IMM + N_RAND_REG
                                  + N_CHAIN + N_MIX + N_X0 + N_DRAIN;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_SLOTS
                                    + rvga_pipe_pkg::PIPE_LATENCY + 20;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
    } exp_t;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        wb_valid;
    logic [31:0] wb_pc;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    exp_t        exp_q[$]; // One entry per issue slot including bubbles.
    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    integer      seed;
    int          cycle_count;

    rvga_core rvga_core_inst (
        .clk_i         (clk),
        .rst_i         (rst),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .wb_valid_o    (wb_valid),
        .wb_pc_o       (wb_pc),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rvga_isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rvga_isa_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rvga_isa_pkg::OPC_LUI};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return enc_i(imm, rs1, 3'b000, rd);
    endfunction

    // Narrow picks x1..x4 so random code is densely dependent.
    function automatic logic [4:0] pick_reg(input logic narrow);
        integer r;
        r = $random(seed);
        if (narrow) begin
            return 5'(r[1:0]) + 5'd1;
        end
        return r[4:0];
    endfunction

    function automatic logic [31:0] rand_imm_instr(input logic narrow);
        integer     r;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [2:0] f3;
        r   = $random(seed);
        rd  = pick_reg(narrow);
        rs1 = pick_reg(narrow);
        f3  = r[14:12];
        if (r[1:0] == 2'b00) begin
            return enc_u(r[31:12], rd);
        end
        if (f3 == 3'b001) begin
            return enc_i({7'h00, r[24:20]}, rs1, f3, rd);
        end
        if (f3 == 3'b101) begin
            return enc_i({r[30] ? 7'h20 : 7'h00, r[24:20]}, rs1, f3, rd);
        end
        return enc_i(r[31:20], rs1, f3, rd);
    endfunction

    function automatic logic [31:0] rand_reg_instr(input logic narrow);
        integer     r;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        r   = $random(seed);
        rd  = pick_reg(narrow);
        rs1 = pick_reg(narrow);
        rs2 = pick_reg(narrow);
        f3  = r[2:0];
        f7  = ((f3 == 3'b000 || f3 == 3'b101) && r[3]) ? 7'h20 : 7'h00;
        return enc_r(f7, rs2, rs1, f3, rd);
    endfunction

    // Architectural effect of one accepted instruction in program order.
    function automatic exp_t ref_step(input logic [31:0] word);
        exp_t        e;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic        legal;
        f7    = word[31:25];
        f3    = word[14:12];
        rd    = word[11:7];
        sh    = word[24:20];
        a     = ref_regs[word[19:15]];
        b     = ref_regs[word[24:20]];
        imm   = {{20{word[31]}}, word[31:20]};
        res   = '0;
        legal = 1'b0;
        if (word[6:0] == rvga_isa_pkg::OPC_LUI) begin
            legal = 1'b1;
            res   = {word[31:12], 12'h000};
        end else if (word[6:0] == rvga_isa_pkg::OPC_OP_IMM) begin
            legal = (f3 == 3'b001) ? (f7 == 7'h00) :
                    (f3 == 3'b101) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
            case (f3)
                3'b000:  res = a + imm;
                3'b001:  res = a << sh;
                3'b010:  res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
                3'b011:  res = (a < imm) ? 32'd1 : 32'd0; // Sign-extended then compared unsigned.
                3'b100:  res = a ^ imm;
                3'b101:  res = f7[5] ? $unsigned($signed(a) >>> sh) : a >> sh;
                3'b110:  res = a | imm;
                default: res = a & imm;
            endcase
        end else if (word[6:0] == rvga_isa_pkg::OPC_OP) begin
            legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
            case (f3)
                3'b000:  res = f7[5] ? a - b : a + b;
                3'b001:  res = a << b[4:0];
                3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b011:  res = (a < b) ? 32'd1 : 32'd0;
                3'b100:  res = a ^ b;
                3'b101:  res = f7[5] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'b110:  res = a | b;
                default: res = a & b;
            endcase
        end
        e.valid = legal;
        e.pc    = ref_pc;
        e.rd    = rd;
        e.data  = res;
        if (legal && rd != 5'd0) begin
            ref_regs[rd] = res;
        end
        ref_pc = ref_pc + 32'd4; // Illegal words still take a PC step.
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic issue(input logic [31:0] word);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = word;
        exp_q.push_back(ref_step(word));
    endtask

    task automatic idle();
        exp_t bubble;
        bubble = '0;
        @(negedge clk);
        instr_valid = 1'b0;
        instr       = $random(seed); // Ignored while not valid.
        exp_q.push_back(bubble);
    endtask

    task automatic run_chains();
        issue(enc_addi(5'd10, 5'd0, 12'd100));
        issue(enc_addi(5'd10, 5'd10, 12'd5));              // Distance one.
        issue(enc_r(7'h00, 5'd10, 5'd10, 3'b000, 5'd11));
        issue(enc_r(7'h20, 5'd10, 5'd11, 3'b000, 5'd12));  // Distances one and two.
        issue(enc_addi(5'd13, 5'd0, 12'hffd));
        issue(enc_addi(5'd20, 5'd0, 12'd1));
        issue(enc_r(7'h00, 5'd0, 5'd13, 3'b100, 5'd15));   // Distance two.
        issue(enc_addi(5'd16, 5'd0, 12'h055));
        issue(enc_addi(5'd21, 5'd0, 12'd2));
        issue(enc_addi(5'd22, 5'd0, 12'd3));
        issue(enc_r(7'h00, 5'd0, 5'd16, 3'b110, 5'd17));   // Distance three.
        issue(enc_addi(5'd18, 5'd0, 12'd11));
        idle();
        issue(enc_addi(5'd18, 5'd18, 12'd1));
        repeat (2) idle();
        issue(enc_addi(5'd18, 5'd18, 12'd1));
        repeat (3) idle();
        issue(enc_r(7'h00, 5'd0, 5'd18, 3'b000, 5'd19));
        issue(enc_addi(5'd23, 5'd0, 12'd1));
        issue(enc_addi(5'd23, 5'd0, 12'd2));
        issue(enc_addi(5'd23, 5'd0, 12'd3));
        issue(enc_r(7'h00, 5'd23, 5'd23, 3'b000, 5'd24));  // Youngest producer wins.
        issue(enc_r(7'h00, 5'd23, 5'd24, 3'b001, 5'd26));
    endtask

    task automatic run_x0_and_illegal();
        issue(enc_addi(5'd0, 5'd0, 12'd5));
        issue(enc_r(7'h00, 5'd11, 5'd10, 3'b000, 5'd0));
        issue(enc_u(20'h12345, 5'd0));
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd27));    // x0 still reads zero.
        issue(32'h0000_2003);                              // Load.
        issue(32'hffff_ffff);
        issue(enc_r(7'h01, 5'd3, 5'd2, 3'b000, 5'd1));     // mul.
        issue(enc_i({7'h10, 5'd3}, 5'd2, 3'b101, 5'd1));
        issue(enc_i({7'h20, 5'd3}, 5'd2, 3'b001, 5'd1));
        issue(enc_addi(5'd28, 5'd0, 12'd1));
    endtask

    initial begin : stimulus
        integer r;
        exp_t   bubble;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        seed        = 59;
        ref_pc      = '0;
        bubble      = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        exp_q.push_back(bubble);
        repeat (N_IDLE_START) idle();
        for (int i = 1; i <= N_ZERO_ADDS; i++) begin
            issue(enc_r(7'h00, 5'(i + 20), 5'(i + 10), 3'b000, 5'(i)));
        end
        repeat (N_RAND_IMM) issue(rand_imm_instr(1'b0));
        repeat (N_RAND_REG) issue(rand_reg_instr(1'b0));
        run_chains();
        repeat (N_MIX) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) begin
                idle();
            end else if (r[2]) begin
                issue(rand_reg_instr(1'b1));
            end else begin
                issue(rand_imm_instr(1'b1));
            end
        end
        run_x0_and_illegal();
        repeat (N_DRAIN) idle();
        @(posedge clk);
        @(negedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

    // Values sampled here are the ones set by the previous edge.
    initial begin : compare
        exp_t e;
        forever begin
            @(posedge clk);
            if (!rst) begin
                if (exp_q.size() > rvga_pipe_pkg::PIPE_LATENCY) begin
                    e = exp_q.pop_front();
                    check_value("wb_valid_o", 32'(e.valid), 32'(wb_valid));
                    if (e.valid) begin
                        check_value("wb_pc_o", e.pc, wb_pc);
                        check_value("wb_rd_o", 32'(e.rd), 32'(wb_rd));
                        check_value("wb_data_o", e.data, wb_data);
                    end
                end else begin
                    check_value("wb_valid_o", 32'd0, 32'(wb_valid));
                end
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > TIMEOUT_CYCLES) begin
                $display("Timeout after %0d cycles before the test sequence finished",
                         cycle_count);
                $display("Simulation failed");
                $fatal(1, "Cycle limit reached");
            end
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
rvga_isa_pkg.sv
rvga_pipe_pkg.sv
regfile.sv
decode_stage.sv
rfetch_stage.sv
execute_stage.sv
rvga_core.sv
tb_rvga_core.sv

// ==== Makefile ====
# Verilator build and run for the rvga pipeline testbench.
VERILATOR ?= verilator
TOP       ?= tb_rvga_core
SRCS      ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR, TOP, SRCS, OBJ_DIR, VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(SRCS)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
